// File: logic/core_settings.svh
// core-wide constants, pulled in with `include by the packages and by RTL that needs them
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first fetch address after reset
`define CORE_RESET_VECTOR 32'h0000_0000

// data and address width
`define CORE_XLEN 32

// architectural integer registers, x0 included
`define CORE_NUM_REGS 32

`endif

// File: logic/fetch_bus_pkg.sv
// bus-level types for instruction memory and retirement, imported by the core and its wrapper
`include "core_settings.svh"

package fetch_bus_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [`CORE_XLEN-1:0] addr_t;
  typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

  typedef struct packed {
    addr_t addr; // byte address, word aligned
  } imem_req_t;

  typedef struct packed {
    word_t data;
  } imem_rsp_t;

  typedef struct packed {
    addr_t    pc;
    reg_idx_t rd; // 0 when nothing is written
    word_t    wdata;
  } retire_t;

endpackage

// File: logic/pipe_pkg.sv
// stage-to-stage payload types and FSM encodings, imported by the pipeline stages
package pipe_pkg;

  import fetch_bus_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    FETCH_IDLE, // no request in flight
    FETCH_WAIT  // request pending or awaiting response
  } fetch_state_e;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef struct packed {
    addr_t pc;
    word_t inst;
  } if_data_t;

  typedef struct packed {
    if_data_t if_data;
    alu_op_e  op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    logic     use_imm; // operand b from imm
    logic     use_pc;  // operand a from pc
  } id_data_t;

  typedef struct packed {
    id_data_t id_data;
    word_t    op_a;
    word_t    op_b;
  } rf_data_t;

endpackage

// File: logic/fetch_unit.sv
// instruction fetch stage that issues one memory request at a time and feeds the decoder
`include "core_settings.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   imem_req_valid,
  output fetch_bus_pkg::imem_req_t imem_req,
  input  logic                   imem_req_ready,
  input  logic                   imem_rsp_valid,
  input  fetch_bus_pkg::imem_rsp_t imem_rsp,
  output logic                   if_valid,
  output pipe_pkg::if_data_t     if_data,
  input  logic                   if_ready
);
  import fetch_bus_pkg::*;
  import pipe_pkg::*;

  fetch_state_e state;
  addr_t        pc;

  assign imem_req = '{addr: pc};

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= FETCH_IDLE;
      pc             <= addr_t'(`CORE_RESET_VECTOR);
      imem_req_valid <= 1'b0;
      if_valid       <= 1'b0;
    end else begin
      if (if_valid && if_ready) begin
        if_valid <= 1'b0;
      end
      case (state)
        FETCH_IDLE: begin
          // output is empty or leaves this cycle, so the next word has a place to land
          if (!if_valid || if_ready) begin
            state          <= FETCH_WAIT;
            imem_req_valid <= 1'b1;
          end
        end
        FETCH_WAIT: begin
          if (imem_req_valid && imem_req_ready) begin
            imem_req_valid <= 1'b0;
            pc             <= pc + addr_t'(4);
          end
          if (imem_rsp_valid) begin
            state    <= FETCH_IDLE;
            if_valid <= 1'b1;
          end
        end
      endcase
    end
  end

  // pc already advanced when the response shows up
  always_ff @(posedge clk) begin
    if (state == FETCH_WAIT && imem_rsp_valid) begin
      if_data.pc   <= pc - addr_t'(4);
      if_data.inst <= imem_rsp.data;
    end
  end

endmodule

// File: logic/decoder.sv
// decode stage, splits an RV32I word into ALU op, register indices and immediate
module decoder (
  input  logic               clk,
  input  logic               rst,
  input  logic               if_valid,
  input  pipe_pkg::if_data_t if_data,
  output logic               if_ready,
  output logic               id_valid,
  output pipe_pkg::id_data_t id_data,
  input  logic               id_ready
);
  import fetch_bus_pkg::*;
  import pipe_pkg::*;

  id_data_t   dec;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = if_data.inst[6:0];
  assign funct3 = if_data.inst[14:12];
  assign funct7 = if_data.inst[31:25];

  always_comb begin
    dec         = '0; // unsupported: pass-b of zero into x0
    dec.if_data = if_data;
    dec.op      = ALU_PASS_B;
    dec.use_imm = 1'b1;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.op      = alu_sel(funct3, funct7[5]);
          dec.rs1     = if_data.inst[19:15];
          dec.rs2     = if_data.inst[24:20];
          dec.rd      = if_data.inst[11:7];
          dec.use_imm = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        // shift immediates carry funct7 in the upper imm bits
        if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'h00 ||
            (funct3 == 3'b101 && funct7 == 7'h20)) begin
          dec.op  = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
          dec.rs1 = if_data.inst[19:15];
          dec.rd  = if_data.inst[11:7];
          dec.imm = word_t'($signed(if_data.inst[31:20]));
        end
      end
      OPC_LUI: begin
        dec.rd  = if_data.inst[11:7];
        dec.imm = {if_data.inst[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        dec.op     = ALU_ADD;
        dec.rd     = if_data.inst[11:7];
        dec.imm    = {if_data.inst[31:12], 12'b0};
        dec.use_pc = 1'b1;
      end
      default: ;
    endcase
  end

  assign if_ready = !id_valid || id_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (if_valid && if_ready) begin
      id_valid <= 1'b1;
    end else if (id_ready) begin
      id_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid && if_ready) begin
      id_data <= dec;
    end
  end

endmodule

// File: logic/reg_read.sv
// register read stage with the register file and a pending-write scoreboard
`include "core_settings.svh"

module reg_read (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   id_valid,
  input  pipe_pkg::id_data_t     id_data,
  output logic                   id_ready,
  output logic                   rf_valid,
  output pipe_pkg::rf_data_t     rf_data,
  input  logic                   rf_ready,
  input  logic                   wb_en,
  input  fetch_bus_pkg::reg_idx_t wb_rd,
  input  fetch_bus_pkg::word_t   wb_data
);
  import fetch_bus_pkg::*;
  import pipe_pkg::*;

  word_t                     rf_mem [`CORE_NUM_REGS];
  logic [`CORE_NUM_REGS-1:0] pending; // one bit per register with a write in flight
  logic                      hazard;
  logic                      take;
  word_t                     rs1_val;
  word_t                     rs2_val;
  word_t                     op_a;
  word_t                     op_b;

  assign rs1_val = (id_data.rs1 == '0) ? '0 : rf_mem[id_data.rs1];
  assign rs2_val = (id_data.rs2 == '0) ? '0 : rf_mem[id_data.rs2];

  assign op_a = id_data.use_pc ? id_data.if_data.pc : rs1_val;
  assign op_b = id_data.use_imm ? id_data.imm : rs2_val;

  // rd is checked too so an older write cannot clear the bit of a younger one
  assign hazard = pending[id_data.rs1] | pending[id_data.rs2] | pending[id_data.rd];

  assign id_ready = (!rf_valid || rf_ready) && !hazard;
  assign take     = id_valid && id_ready;

  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      rf_mem[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb_en) begin
        pending[wb_rd] <= 1'b0;
      end
      if (take && id_data.rd != '0) begin
        pending[id_data.rd] <= 1'b1; // wins over a same-cycle clear
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rf_valid <= 1'b0;
    end else if (take) begin
      rf_valid <= 1'b1;
    end else if (rf_ready) begin
      rf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rf_data.id_data <= id_data;
      rf_data.op_a    <= op_a;
      rf_data.op_b    <= op_b;
    end
  end

endmodule

// File: logic/execute_unit.sv
// execute stage, ALU into the retire register and register-file write on retirement
module execute_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rf_valid,
  input  pipe_pkg::rf_data_t      rf_data,
  output logic                    rf_ready,
  output logic                    retire_valid,
  output fetch_bus_pkg::retire_t  retire,
  input  logic                    retire_ready,
  output logic                    wb_en,
  output fetch_bus_pkg::reg_idx_t wb_rd,
  output fetch_bus_pkg::word_t    wb_data
);
  import fetch_bus_pkg::*;
  import pipe_pkg::*;

  word_t      a;
  word_t      b;
  logic [4:0] shamt;
  word_t      result;

  assign a     = rf_data.op_a;
  assign b     = rf_data.op_b;
  assign shamt = b[4:0];

  always_comb begin
    case (rf_data.id_data.op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = word_t'($signed(a) < $signed(b));
      ALU_SLTU: result = word_t'(a < b);
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = b; // pass-b
    endcase
  end

  assign rf_ready = !retire_valid || retire_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else if (rf_valid && rf_ready) begin
      retire_valid <= 1'b1;
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rf_valid && rf_ready) begin
      retire <= '{pc: rf_data.id_data.if_data.pc, rd: rf_data.id_data.rd, wdata: result};
    end
  end

  // write back exactly on the retire handshake
  assign wb_en   = retire_valid && retire_ready;
  assign wb_rd   = retire.rd;
  assign wb_data = retire.wdata;

endmodule

// File: logic/core_wrap.sv
// top level of the integer core, flat instruction memory and retirement ports
module core_wrap (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    imem_req_valid,
  output fetch_bus_pkg::addr_t    imem_req_addr,
  input  logic                    imem_req_ready,
  input  logic                    imem_rsp_valid,
  input  fetch_bus_pkg::word_t    imem_rsp_data,
  output logic                    retire_valid,
  output fetch_bus_pkg::addr_t    retire_pc,
  output fetch_bus_pkg::reg_idx_t retire_rd,
  output fetch_bus_pkg::word_t    retire_wdata,
  input  logic                    retire_ready
);
  import fetch_bus_pkg::*;
  import pipe_pkg::*;

  imem_req_t imem_req;
  imem_rsp_t imem_rsp;
  retire_t   retire;

  logic     if_valid, if_ready;
  if_data_t if_data;
  logic     id_valid, id_ready;
  id_data_t id_data;
  logic     rf_valid, rf_ready;
  rf_data_t rf_data;

  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  assign imem_req_addr = imem_req.addr;
  assign imem_rsp      = '{data: imem_rsp_data};
  assign retire_pc     = retire.pc;
  assign retire_rd     = retire.rd;
  assign retire_wdata  = retire.wdata;

  fetch_unit i_fetch (
    .clk, .rst, .imem_req_valid, .imem_req, .imem_req_ready, .imem_rsp_valid, .imem_rsp,
    .if_valid, .if_data, .if_ready
  );

  decoder i_decoder (
    .clk, .rst, .if_valid, .if_data, .if_ready, .id_valid, .id_data, .id_ready
  );

  reg_read i_reg_read (
    .clk, .rst, .id_valid, .id_data, .id_ready, .rf_valid, .rf_data, .rf_ready,
    .wb_en, .wb_rd, .wb_data
  );

  execute_unit i_execute (
    .clk, .rst, .rf_valid, .rf_data, .rf_ready, .retire_valid, .retire, .retire_ready,
    .wb_en, .wb_rd, .wb_data
  );

endmodule

// File: verification/clock_gen.sv
// testbench clock and reset source, 100 ns clock with reset held for the first 16 cycles
module clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  int count = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (count < 16) count <= count + 1;
  end

  assign rst = (count < 16); // drops on the 16th rising edge
endmodule

// File: verification/retire_checker.sv
// testbench monitor, compares the fetch start and every retirement with the expected case
`include "core_settings.svh"

module retire_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    imem_req_valid,
  input  fetch_bus_pkg::addr_t    imem_req_addr,
  input  logic                    imem_req_ready,
  input  logic                    retire_valid,
  input  fetch_bus_pkg::addr_t    retire_pc,
  input  fetch_bus_pkg::reg_idx_t retire_rd,
  input  fetch_bus_pkg::word_t    retire_wdata,
  input  logic                    retire_ready,
  input  int                      num_cases,
  input  fetch_bus_pkg::reg_idx_t exp_rd,
  input  fetch_bus_pkg::word_t    exp_wdata,
  output int                      checked,
  output int                      error_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_bus_pkg::*;

  logic    in_reset;  // first cycle after reset not looked at yet
  logic    first_req; // first fetch request seen
  logic    stalled;   // retirement offered and refused last cycle
  retire_t held_rec;

  task automatic check_value(input string name, input word_t expected, input word_t actual,
                             inout int errs);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      errs++;
    end
  endtask

  always @(posedge clk) begin
    int      errs;
    retire_t rec;
    errs = 0;
    rec  = '{pc: retire_pc, rd: retire_rd, wdata: retire_wdata};
    if (rst) begin
      in_reset    <= 1'b1;
      first_req   <= 1'b0;
      stalled     <= 1'b0;
      checked     <= 0;
      error_count <= 0;
    end else begin
      if (in_reset) begin
        check_value("imem_req_valid", '0, word_t'(imem_req_valid), errs);
        check_value("retire_valid", '0, word_t'(retire_valid), errs);
        in_reset <= 1'b0;
      end
      if (imem_req_valid && imem_req_ready && !first_req) begin
        check_value("imem_req_addr", `CORE_RESET_VECTOR, imem_req_addr, errs);
        first_req <= 1'b1;
      end
      if (stalled && (!retire_valid || rec !== held_rec)) begin
        $display("at %0d ns the retirement changed or vanished while retire_ready was low",
                 $time);
        errs++;
      end
      if (retire_valid && retire_ready && checked < num_cases) begin
        check_value("retire_pc", word_t'(checked * 4), retire_pc, errs); // program order
        check_value("retire_rd", word_t'(exp_rd), word_t'(retire_rd), errs);
        check_value("retire_wdata", exp_wdata, retire_wdata, errs);
        checked <= checked + 1;
      end
      stalled     <= retire_valid && !retire_ready;
      held_rec    <= rec;
      error_count <= error_count + errs;
    end
  end
endmodule

// File: verification/tb_core.sv
// testbench top, loads the cases, acts as instruction memory and stalls retirement at random
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_bus_pkg::*;

  localparam int MAX_CASES = 64;

  logic     clk;
  logic     rst;
  logic     imem_req_valid;
  addr_t    imem_req_addr;
  logic     imem_req_ready = 1'b0;
  logic     imem_rsp_valid = 1'b0;
  word_t    imem_rsp_data  = '0;
  logic     retire_valid;
  addr_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_wdata;
  logic     retire_ready   = 1'b0;

  word_t       cases [MAX_CASES*3]; // program word, rd, write data for each case
  int          num_cases;
  int          checked;
  int          error_count;
  int          cycles;
  logic [15:0] lfsr;
  logic        rsp_busy;
  int          rsp_wait;
  addr_t       rsp_addr;

  function automatic word_t fill_word(input int idx);
    return 32'hfeed_0000 ^ idx;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  function automatic word_t program_word(input addr_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < num_cases) return cases[idx*3];
    return 32'h0000_0013; // nop past the end of the program
  endfunction

  clock_gen i_clock_gen (.clk, .rst);

  core_wrap i_dut (
    .clk, .rst, .imem_req_valid, .imem_req_addr, .imem_req_ready, .imem_rsp_valid,
    .imem_rsp_data, .retire_valid, .retire_pc, .retire_rd, .retire_wdata, .retire_ready
  );

  retire_checker i_checker (
    .clk, .rst, .imem_req_valid, .imem_req_addr, .imem_req_ready, .retire_valid, .retire_pc,
    .retire_rd, .retire_wdata, .retire_ready, .num_cases,
    .exp_rd(reg_idx_t'(cases[checked*3+1])), .exp_wdata(cases[checked*3+2]),
    .checked, .error_count
  );

  always @(posedge clk) begin
    logic b0;
    logic b1;
    if (rst) begin
      lfsr = 16'd22;
      imem_req_ready <= 1'b0;
      imem_rsp_valid <= 1'b0;
      retire_ready   <= 1'b0;
      rsp_busy       <= 1'b0;
    end else begin
      draw_bit(b0);
      imem_req_ready <= b0;
      draw_bit(b0);
      draw_bit(b1);
      retire_ready   <= b0 | b1; // refused about one cycle in four
      imem_rsp_valid <= 1'b0;
      if (rsp_busy && rsp_wait == 0) begin
        imem_rsp_valid <= 1'b1;
        imem_rsp_data  <= program_word(rsp_addr);
        rsp_busy       <= 1'b0;
      end else if (rsp_busy) begin
        rsp_wait <= rsp_wait - 1;
      end
      if (imem_req_valid && imem_req_ready) begin
        draw_bit(b0);
        draw_bit(b1);
        rsp_busy <= 1'b1;
        rsp_addr <= imem_req_addr;
        rsp_wait <= int'({b1, b0}); // 0 to 3 idle cycles before the response
      end
    end
  end

  initial begin
    for (int i = 0; i < MAX_CASES * 3; i++) cases[i] = fill_word(i);
    $readmemh("verification/core_cases.txt", cases);
    num_cases = 0;
    while (num_cases < MAX_CASES && cases[num_cases*3] != fill_word(num_cases * 3)) begin
      num_cases++;
    end
    cycles = 0;
    while (checked !== num_cases && cycles < 16 + 40 * num_cases) begin
      @(posedge clk);
      cycles++;
    end
    if (num_cases == 0) $display("no cases could be read from the cases file");
    if (checked != num_cases) begin
      $display("timeout after %0d cycles, only %0d cases retired", cycles, checked);
    end
    $display("retired %0d of %0d cases, %0d errors", checked, num_cases, error_count);
    if (num_cases > 0 && checked == num_cases && error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end
endmodule

// File: verification/core_cases.txt
// columns: program word, expected rd, expected write data, all hex; pc is 4 x case index
// writes to x0 and unsupported encodings retire with rd 00
00500093 01 00000005
FFD00113 02 FFFFFFFD
002081B3 03 00000002
40118233 04 FFFFFFFD
123452B7 05 12345000
00001317 06 00001014
40125393 07 FFFFFFFE
00708013 00 0000000C
00506433 08 12345000
001224B3 09 00000001
00123533 0A 00000000
00000073 00 00000000
FFF4C593 0B FFFFFFFE
00129633 0C 468A0000

// File: filelist.f
+incdir+logic
logic/fetch_bus_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/reg_read.sv
logic/execute_unit.sv
logic/core_wrap.sv
verification/clock_gen.sv
verification/retire_checker.sv
verification/tb_core.sv

// File: Makefile
# Verilator build and run for the core testbench

SIM = obj_dir/Vtb_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_core \
		-f filelist.f -Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
